/* filelist.f */
+incdir+logic
logic/offload_pkg.sv
logic/ipu_pkg.sv
logic/offload_issuer.sv
logic/spill_register.sv
logic/int_processing_unit.sv
logic/offload_complex.sv
tb/offload_checker.sv
tb/tb_offload_complex.sv

/* logic/int_processing_unit.sv */
// --------------------------------------------------------------------
// Integer processing unit: single-cycle multiplier and
// iterative restoring divider behind one FSM
// --------------------------------------------------------------------

`timescale 1ns/100ps

`include "offload_settings.svh"

module int_processing_unit
  import offload_pkg::*, ipu_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Operation in
  input  logic                       op_valid_i,
  output logic                       op_ready_o,
  input  offload_op_e                op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] argb_i,
  input  logic [`OFFLOAD_ID_W-1:0]   id_i,
  input  logic                       illegal_i,
  // Result out
  output logic                       res_valid_o,
  input  logic                       res_ready_i,
  output logic [`OFFLOAD_DATA_W-1:0] res_data_o,
  output logic [`OFFLOAD_ID_W-1:0]   res_id_o,
  output logic                       res_error_o
);

  localparam int W     = `OFFLOAD_DATA_W;
  localparam int CNT_W = $clog2(`IPU_DIV_STEPS + 1);

  ipu_state_e state_q, state_d;
  logic [CNT_W-1:0] cnt_q;

  // Operation payload
  offload_op_e              op_q;
  logic                     illegal_q;
  logic [`OFFLOAD_ID_W-1:0] id_q;
  // Operand A, shifted into quotient bits while dividing
  logic [W-1:0]             quot_q;
  logic [W-1:0]             divisor_q;
  logic [W-1:0]             rem_q;
  logic [W-1:0]             res_q;
  logic                     err_q;

  logic           op_fire;
  logic           res_fire;
  logic           is_div;
  logic [2*W-1:0] product;
  logic [W:0]     rem_shift;
  logic [W:0]     rem_sub;
  logic           step_ok;

  assign op_ready_o  = (state_q == IPU_IDLE);
  assign res_valid_o = (state_q == IPU_DONE);
  assign res_data_o  = res_q;
  assign res_id_o    = id_q;
  assign res_error_o = err_q;

  assign op_fire  = op_valid_i & op_ready_o;
  assign res_fire = res_valid_o & res_ready_i;
  assign is_div   = ~illegal_i & ((op_i == OP_DIVU) | (op_i == OP_REMU));

  assign product = quot_q * divisor_q;

  // One restoring step: shift in the next dividend bit, try to subtract
  // A zero divisor always subtracts, giving all ones and rem = dividend
  assign rem_shift = {rem_q, quot_q[W-1]};
  assign step_ok   = (rem_shift >= {1'b0, divisor_q});
  assign rem_sub   = step_ok ? (rem_shift - {1'b0, divisor_q}) : rem_shift;

  // ------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IPU_IDLE: begin
        if (op_fire) begin
          state_d = is_div ? IPU_DIV : IPU_MUL;
        end
      end
      IPU_MUL: state_d = IPU_DONE;
      IPU_DIV: begin
        if (cnt_q == '0) begin
          state_d = IPU_DONE;
        end
      end
      IPU_DONE: begin
        if (res_fire) begin
          state_d = IPU_IDLE;
        end
      end
      default: state_d = IPU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IPU_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (op_fire) begin
        cnt_q <= CNT_W'(`IPU_DIV_STEPS);
      end else if ((state_q == IPU_DIV) && (cnt_q != '0)) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    case (state_q)
      IPU_IDLE: begin
        if (op_fire) begin
          op_q      <= op_i;
          illegal_q <= illegal_i;
          id_q      <= id_i;
          quot_q    <= arga_i;
          divisor_q <= argb_i;
          rem_q     <= '0;
        end
      end
      IPU_MUL: begin
        // Illegal codes also pass here and return zero
        if (illegal_q) begin
          res_q <= '0;
        end else if (op_q == OP_MULHU) begin
          res_q <= product[2*W-1:W];
        end else begin
          res_q <= product[W-1:0];
        end
        err_q <= illegal_q;
      end
      IPU_DIV: begin
        if (cnt_q != '0) begin
          quot_q <= {quot_q[W-2:0], step_ok};
          rem_q  <= rem_sub[W-1:0];
        end else begin
          res_q <= (op_q == OP_REMU) ? rem_q : quot_q;
          err_q <= 1'b0;
        end
      end
      default: ;
    endcase
  end

endmodule

/* logic/ipu_pkg.sv */
// --------------------------------------------------------------------
// Internal types of the integer processing unit
// --------------------------------------------------------------------

package ipu_pkg;

  // Unit FSM states
  typedef enum logic [1:0] {
    IPU_IDLE = 2'd0,
    IPU_MUL  = 2'd1,
    IPU_DIV  = 2'd2,
    IPU_DONE = 2'd3
  } ipu_state_e;

endpackage

/* logic/offload_complex.sv */
// --------------------------------------------------------------------
// Offload complex top level: issuer, request and response spill
// registers and the integer processing unit
// --------------------------------------------------------------------

`timescale 1ns/100ps

`include "offload_settings.svh"

module offload_complex
  import offload_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Command port
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  logic [3:0]                 cmd_op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_argb_i,
  // Response port
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [`OFFLOAD_DATA_W-1:0] rsp_data_o,
  output logic [`OFFLOAD_ID_W-1:0]   rsp_id_o,
  output logic                       rsp_error_o
);

  localparam int W     = `OFFLOAD_DATA_W;
  localparam int OP_W  = $bits(offload_op_e);
  localparam int REQ_W = OP_W + 2 * W + `OFFLOAD_ID_W + 1;
  localparam int RSP_W = W + `OFFLOAD_ID_W + 1;

  // Issuer to request spill register
  logic                     iss_valid, iss_ready;
  offload_op_e              iss_op;
  logic [W-1:0]             iss_arga, iss_argb;
  logic [`OFFLOAD_ID_W-1:0] iss_id;
  logic                     iss_illegal;
  logic [REQ_W-1:0]         req_d_data, req_q_data;

  // Request spill register to unit
  logic                     ipu_valid, ipu_ready;
  logic [OP_W-1:0]          ipu_op_raw;
  logic [W-1:0]             ipu_arga, ipu_argb;
  logic [`OFFLOAD_ID_W-1:0] ipu_id;
  logic                     ipu_illegal;

  // Unit to response spill register
  logic                     res_valid, res_ready;
  logic [W-1:0]             res_data;
  logic [`OFFLOAD_ID_W-1:0] res_id;
  logic                     res_error;
  logic [RSP_W-1:0]         rsp_d_data, rsp_q_data;

  offload_issuer u_issuer (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .cmd_valid_i   ( cmd_valid_i ),
    .cmd_ready_o   ( cmd_ready_o ),
    .cmd_op_i      ( cmd_op_i    ),
    .cmd_arga_i    ( cmd_arga_i  ),
    .cmd_argb_i    ( cmd_argb_i  ),
    .req_valid_o   ( iss_valid   ),
    .req_ready_i   ( iss_ready   ),
    .req_op_o      ( iss_op      ),
    .req_arga_o    ( iss_arga    ),
    .req_argb_o    ( iss_argb    ),
    .req_id_o      ( iss_id      ),
    .req_illegal_o ( iss_illegal )
  );

  // Cut the request path
  assign req_d_data = {iss_op, iss_arga, iss_argb, iss_id, iss_illegal};

  spill_register #(
    .WIDTH ( REQ_W )
  ) u_req_spill (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .valid_i ( iss_valid  ),
    .ready_o ( iss_ready  ),
    .data_i  ( req_d_data ),
    .valid_o ( ipu_valid  ),
    .ready_i ( ipu_ready  ),
    .data_o  ( req_q_data )
  );

  assign {ipu_op_raw, ipu_arga, ipu_argb, ipu_id, ipu_illegal} = req_q_data;

  int_processing_unit u_ipu (
    .clk_i       ( clk_i                      ),
    .rst_i       ( rst_i                      ),
    .op_valid_i  ( ipu_valid                  ),
    .op_ready_o  ( ipu_ready                  ),
    .op_i        ( offload_op_e'(ipu_op_raw)  ),
    .arga_i      ( ipu_arga                   ),
    .argb_i      ( ipu_argb                   ),
    .id_i        ( ipu_id                     ),
    .illegal_i   ( ipu_illegal                ),
    .res_valid_o ( res_valid                  ),
    .res_ready_i ( res_ready                  ),
    .res_data_o  ( res_data                   ),
    .res_id_o    ( res_id                     ),
    .res_error_o ( res_error                  )
  );

  // Cut the response path
  assign rsp_d_data = {res_data, res_id, res_error};

  spill_register #(
    .WIDTH ( RSP_W )
  ) u_rsp_spill (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( res_valid   ),
    .ready_o ( res_ready   ),
    .data_i  ( rsp_d_data  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_q_data  )
  );

  assign {rsp_data_o, rsp_id_o, rsp_error_o} = rsp_q_data;

endmodule

/* logic/offload_issuer.sv */
// --------------------------------------------------------------------
// Command issuer: opcode check, id stamping and request forwarding
// --------------------------------------------------------------------

`timescale 1ns/100ps

`include "offload_settings.svh"

module offload_issuer
  import offload_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Command from outside
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  logic [3:0]                 cmd_op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_argb_i,
  // Request towards the unit
  output logic                       req_valid_o,
  input  logic                       req_ready_i,
  output offload_op_e                req_op_o,
  output logic [`OFFLOAD_DATA_W-1:0] req_arga_o,
  output logic [`OFFLOAD_DATA_W-1:0] req_argb_o,
  output logic [`OFFLOAD_ID_W-1:0]   req_id_o,
  output logic                       req_illegal_o
);

  logic [`OFFLOAD_ID_W-1:0] id_q;
  logic                     cmd_fire;
  logic                     op_legal;

  // Handshake passes straight through
  assign req_valid_o = cmd_valid_i;
  assign cmd_ready_o = req_ready_i;
  assign cmd_fire    = cmd_valid_i & req_ready_i;

  // Only the four named opcodes are legal
  always_comb begin
    case (cmd_op_i)
      OP_MUL, OP_MULHU, OP_DIVU, OP_REMU: op_legal = 1'b1;
      default:                            op_legal = 1'b0;
    endcase
  end

  assign req_op_o      = offload_op_e'(cmd_op_i);
  assign req_arga_o    = cmd_arga_i;
  assign req_argb_o    = cmd_argb_i;
  assign req_id_o      = id_q;
  assign req_illegal_o = ~op_legal;

  // Id counter, wraps naturally at its width
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      id_q <= '0;
    end else if (cmd_fire) begin
      id_q <= id_q + 1'b1;
    end
  end

endmodule

/* logic/offload_pkg.sv */
// --------------------------------------------------------------------
// Offload interface types: the command opcode encoding
// --------------------------------------------------------------------

package offload_pkg;

  // Opcode field of an offload command
  // Codes outside this list are illegal and come back with the error flag
  typedef enum logic [3:0] {
    OP_MUL   = 4'd0,
    OP_MULHU = 4'd1,
    OP_DIVU  = 4'd2,
    OP_REMU  = 4'd3
  } offload_op_e;

  // MUL    low half of the product
  // MULHU  high half of the unsigned product
  // DIVU   unsigned quotient
  // REMU   unsigned remainder

endpackage

/* logic/offload_settings.svh */
// --------------------------------------------------------------------
// Width and iteration settings shared by the offload complex
// --------------------------------------------------------------------

`ifndef OFFLOAD_SETTINGS_SVH
`define OFFLOAD_SETTINGS_SVH

// Operand and result width
`define OFFLOAD_DATA_W 32

// Transaction id width, ids wrap at 2**OFFLOAD_ID_W
`define OFFLOAD_ID_W 5

// One divider iteration per result bit
`define IPU_DIV_STEPS `OFFLOAD_DATA_W

`endif

/* logic/spill_register.sv */
// --------------------------------------------------------------------
// Two-entry valid/ready register slice
// --------------------------------------------------------------------

`timescale 1ns/100ps

module spill_register #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             a_full_q;
  logic             b_full_q;
  logic [WIDTH-1:0] a_data_q;
  logic [WIDTH-1:0] b_data_q;

  logic in_fire;
  logic out_fire;
  logic a_free;
  logic a_from_b;
  logic a_from_in;
  logic b_from_in;

  // B is only ever full while A is full
  assign ready_o  = ~(a_full_q & b_full_q);
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;

  assign in_fire  = valid_i & ready_o;
  assign out_fire = a_full_q & ready_i;

  // A can take a new item this cycle
  assign a_free    = ~a_full_q | out_fire;
  // B is older than the input, so it refills A first
  assign a_from_b  = a_free & b_full_q;
  assign a_from_in = a_free & ~b_full_q & in_fire;
  assign b_from_in = ~a_free & in_fire;

  // ------------------------------------------------------------------
  // Occupancy flags
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= ~a_free | a_from_b | a_from_in;
      b_full_q <= (b_full_q & ~a_from_b) | b_from_in;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (a_from_b) begin
      a_data_q <= b_data_q;
    end else if (a_from_in) begin
      a_data_q <= data_i;
    end
    if (b_from_in) begin
      b_data_q <= data_i;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the offload complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_offload_complex \
  -f filelist.f \
  -Mdir obj_dir -o sim_offload
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_offload)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

/* tb/offload_checker.sv */
// --------------------------------------------------------------------
// Response checker: in-order reference model, id tracking and
// handshake stability checks on the offload complex ports
// --------------------------------------------------------------------

`timescale 1ns/100ps

`include "offload_settings.svh"

module offload_checker
  import offload_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       done_i,
  input  logic                       cmd_valid_i,
  input  logic                       cmd_ready_i,
  input  logic [3:0]                 cmd_op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] cmd_argb_i,
  input  logic                       rsp_valid_i,
  input  logic                       rsp_ready_i,
  input  logic [`OFFLOAD_DATA_W-1:0] rsp_data_i,
  input  logic [`OFFLOAD_ID_W-1:0]   rsp_id_i,
  input  logic                       rsp_error_i,
  output int                         value_err_o,
  output int                         proto_err_o,
  output int                         rsp_cnt_o,
  output int                         pending_o
);

  localparam int W = `OFFLOAD_DATA_W;

  // Expected responses in command order
  logic [W-1:0]             exp_data_q[$];
  logic [`OFFLOAD_ID_W-1:0] exp_id_q[$];
  logic                     exp_err_q[$];

  logic [`OFFLOAD_ID_W-1:0] next_id    = '0;
  int                       value_errs = 0;
  int                       proto_errs = 0;
  int                       rsp_cnt    = 0;
  int                       pending    = 0;
  logic                     rst_q      = 1'b1;
  logic                     done_q     = 1'b0;
  logic                     hold_q     = 1'b0;
  logic                     stall_seen = 1'b0;
  logic [W-1:0]             hold_data;
  logic [`OFFLOAD_ID_W-1:0] hold_id;
  logic                     hold_err;

  assign value_err_o = value_errs;
  assign proto_err_o = proto_errs;
  assign rsp_cnt_o   = rsp_cnt;
  assign pending_o   = pending;

  // Result by the operation rules, zero for illegal codes
  function automatic logic [W-1:0] model_result(input logic [3:0] op,
                                                input logic [W-1:0] a,
                                                input logic [W-1:0] b);
    logic [2*W-1:0] prod;
    prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    case (op)
      OP_MUL:   return prod[W-1:0];
      OP_MULHU: return prod[2*W-1:W];
      OP_DIVU:  return (b == '0) ? '1 : a / b;
      OP_REMU:  return (b == '0) ? a : a % b;
      default:  return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      next_id = '0;
      hold_q  = 1'b0;
    end else begin
      // First edge after reset
      if (rst_q) begin
        check_value("rsp_valid_o", 32'(rsp_valid_i), 32'd0);
        check_value("cmd_ready_o", 32'(cmd_ready_i), 32'd1);
      end
      // A stalled response must stay put
      if (hold_q) begin
        if (rsp_valid_i !== 1'b1) begin
          $display("Error at %0t: rsp_valid_o dropped before the response was taken", $time);
          proto_errs++;
        end else begin
          check_value("rsp_data_o", rsp_data_i, hold_data);
          check_value("rsp_id_o", 32'(rsp_id_i), 32'(hold_id));
          check_value("rsp_error_o", 32'(rsp_error_i), 32'(hold_err));
        end
      end
      if (!cmd_ready_i) begin
        stall_seen = 1'b1;
      end
      if (cmd_valid_i && cmd_ready_i) begin
        exp_data_q.push_back(model_result(cmd_op_i, cmd_arga_i, cmd_argb_i));
        exp_id_q.push_back(next_id);
        exp_err_q.push_back(cmd_op_i > 4'd3);
        next_id = next_id + 1'b1;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        rsp_cnt++;
        if (exp_data_q.size() == 0) begin
          $display("Error at %0t: response arrived with no command outstanding", $time);
          proto_errs++;
        end else begin
          check_value("rsp_data_o", rsp_data_i, exp_data_q.pop_front());
          check_value("rsp_id_o", 32'(rsp_id_i), 32'(exp_id_q.pop_front()));
          check_value("rsp_error_o", 32'(rsp_error_i), 32'(exp_err_q.pop_front()));
        end
      end
      hold_q    = rsp_valid_i && !rsp_ready_i;
      hold_data = rsp_data_i;
      hold_id   = rsp_id_i;
      hold_err  = rsp_error_i;
      if (done_i && !done_q) begin
        if (exp_data_q.size() != 0) begin
          $display("Missing responses: %0d expected responses never came back",
                   exp_data_q.size());
          proto_errs++;
        end
        if (!stall_seen) begin
          $display("cmd_ready_o never fell, so the pipe was never seen full");
          proto_errs++;
        end
      end
      done_q = done_i;
    end
    rst_q   = rst_i;
    pending = exp_data_q.size();
  end

endmodule

/* tb/tb_offload_complex.sv */
// --------------------------------------------------------------------
// Testbench top for the offload complex: clock, reset, random
// commands, response back-pressure, timeout and final report
// --------------------------------------------------------------------

`timescale 1ns/100ps

`include "offload_settings.svh"

module tb_offload_complex;

  localparam int          N_CMDS     = 400;
  localparam int          CMD_CYCLES = `IPU_DIV_STEPS + 8;
  localparam int          MAX_CYCLES = N_CMDS * CMD_CYCLES + 200;
  // Drain window for responses still in the pipe after the last command
  localparam int          DRAIN_MAX  = 10 * CMD_CYCLES;
  localparam logic [31:0] SEED       = 32'h7952_13ac;

  logic                       clk_i;
  logic                       rst_i;
  logic                       cmd_valid_i;
  logic                       cmd_ready_o;
  logic [3:0]                 cmd_op_i;
  logic [`OFFLOAD_DATA_W-1:0] cmd_arga_i;
  logic [`OFFLOAD_DATA_W-1:0] cmd_argb_i;
  logic                       rsp_valid_o;
  logic                       rsp_ready_i;
  logic [`OFFLOAD_DATA_W-1:0] rsp_data_o;
  logic [`OFFLOAD_ID_W-1:0]   rsp_id_o;
  logic                       rsp_error_o;

  logic        run_done;
  logic        cmd_taken;
  logic [31:0] rng;
  int          value_errs;
  int          proto_errs;
  int          rsp_count;
  int          pending;
  int          cycle_cnt;
  int          accepted;
  int          gap;
  int          stall;
  int          drain;

  offload_complex dut0 (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_ready_o ( cmd_ready_o ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_arga_i  ( cmd_arga_i  ),
    .cmd_argb_i  ( cmd_argb_i  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_data_o  ( rsp_data_o  ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_error_o ( rsp_error_o )
  );

  offload_checker u_checker (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .done_i      ( run_done    ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_ready_i ( cmd_ready_o ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_arga_i  ( cmd_arga_i  ),
    .cmd_argb_i  ( cmd_argb_i  ),
    .rsp_valid_i ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_data_i  ( rsp_data_o  ),
    .rsp_id_i    ( rsp_id_o    ),
    .rsp_error_i ( rsp_error_o ),
    .value_err_o ( value_errs  ),
    .proto_err_o ( proto_errs  ),
    .rsp_cnt_o   ( rsp_count   ),
    .pending_o   ( pending     )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Operand with a bias towards zero, all ones and other corners
  task automatic draw_operand(output logic [31:0] v);
    logic [31:0] sel;
    rng = xorshift32(rng);
    sel = rng;
    rng = xorshift32(rng);
    case (sel[3:0])
      4'd0:    v = 32'h0000_0000;
      4'd1:    v = 32'hffff_ffff;
      4'd2:    v = 32'h8000_0000;
      4'd3:    v = 32'h0000_0001;
      4'd4:    v = {28'd0, rng[3:0]};
      default: v = rng;
    endcase
  endtask

  task automatic present_command();
    rng = xorshift32(rng);
    if (rng[3:0] == 4'd0) begin
      // Illegal code somewhere in 4..15
      cmd_op_i = (rng[7:4] < 4'd4) ? rng[7:4] + 4'd4 : rng[7:4];
    end else begin
      cmd_op_i = {2'b00, rng[5:4]};
    end
    draw_operand(cmd_arga_i);
    draw_operand(cmd_argb_i);
    cmd_valid_i = 1'b1;
  endtask

  // Mostly ready, short dips, and now and then a long stall
  task automatic drive_response_ready();
    if (stall > 0) begin
      stall--;
      rsp_ready_i = 1'b0;
    end else begin
      rng = xorshift32(rng);
      if (rng[7:0] == 8'd0) begin
        stall = 20 + int'(rng[12:8]);
        rsp_ready_i = 1'b0;
      end else if (rng[10:8] == 3'd0) begin
        stall = int'(rng[12:11]);
        rsp_ready_i = 1'b0;
      end else begin
        rsp_ready_i = 1'b1;
      end
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Summary: %0d responses checked, %0d value errors, %0d protocol errors",
             rsp_count, value_errs, proto_errs);
    if (!timed_out && value_errs == 0 && proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Acceptance seen at the rising edge, read back on the falling edge
  always @(posedge clk_i) begin
    cmd_taken <= cmd_valid_i & cmd_ready_o;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
        $display("Timeout: run did not complete within %0d clock cycles", MAX_CYCLES);
        finish_run(1'b1);
      end
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    rng         = SEED;
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_op_i    = 4'd0;
    cmd_arga_i  = '0;
    cmd_argb_i  = '0;
    rsp_ready_i = 1'b0;
    run_done    = 1'b0;
    accepted    = 0;
    gap         = 0;
    stall       = 0;
    drain       = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    while (accepted < N_CMDS || (pending != 0 && drain < DRAIN_MAX)) begin
      @(negedge clk_i);
      if (accepted >= N_CMDS) begin
        drain++;
      end
      drive_response_ready();
      if (cmd_valid_i && cmd_taken) begin
        accepted++;
        cmd_valid_i = 1'b0;
        rng = xorshift32(rng);
        gap = (rng[2:0] < 3'd5) ? 0 : int'(rng[4:3]);
      end
      if (!cmd_valid_i && accepted < N_CMDS) begin
        if (gap > 0) begin
          gap--;
        end else begin
          present_command();
        end
      end
    end
    run_done = 1'b1;
    repeat (2) @(negedge clk_i);
    finish_run(1'b0);
  end

endmodule
